// File: logic/blur_pkg.sv
package blur_pkg;

    // Window shape of the blur kernel
    localparam int KERNEL_ROWS = 5;
    localparam int KERNEL_COLS = 7;

    // Colour channels per pixel, index 0 red, 1 green, 2 blue
    localparam int NUM_CHANNELS = 3;

    // Kernel weights sum to 64, so the result is normalised by 6
    localparam int NORM_SHIFT = 6;

    // Blurred channels above this level trigger background averaging
    localparam int NOISE_LEVEL = 10;

    // One 4-bit colour channel
    typedef logic [3:0] channel_t;

    // RGB444 pixel, red in the top bits
    typedef struct packed {
        channel_t red;
        channel_t green;
        channel_t blue;
    } rgb_pixel_t;

    // Taps of one channel, indexed [row][column], row 0 is the oldest row
    typedef channel_t [KERNEL_ROWS-1:0][KERNEL_COLS-1:0] chan_window_t;

    // Taps of all three channels, indexed by channel number
    typedef chan_window_t [NUM_CHANNELS-1:0] rgb_window_t;

    // Weighted sum of 35 taps, at most 15 * 64 = 960
    typedef logic [9:0] blur_acc_t;

    // Power-of-two weights, applied as left shifts
    localparam int KERNEL_WEIGHT [KERNEL_ROWS][KERNEL_COLS] = '{
        '{1, 1, 2, 2, 2, 1, 1},
        '{1, 2, 2, 4, 2, 2, 1},
        '{0, 2, 4, 4, 4, 2, 0},
        '{1, 2, 2, 4, 2, 2, 1},
        '{1, 1, 2, 2, 2, 1, 1}
    };

endpackage

// File: logic/pixel_window.sv
`timescale 1ns/1ps

module pixel_window #(
    parameter int IMG_WIDTH = 320
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  blur_pkg::rgb_pixel_t  pixel_in,
    input  logic                  valid,
    input  logic                  ready,
    input  logic                  sop,
    output blur_pkg::rgb_window_t window,
    output blur_pkg::rgb_pixel_t  oldest,
    output logic                  win_valid
);
    import blur_pkg::*;

    // Beats needed before the first window is complete (4 rows plus 6 pixels)
    localparam int WARM_BEATS = (KERNEL_ROWS - 1) * IMG_WIDTH + KERNEL_COLS - 1;
    localparam int DEPTH      = WARM_BEATS + 1;
    localparam int CNT_W      = $clog2(WARM_BEATS + 1);

    typedef logic [CNT_W-1:0] warm_cnt_t;

    // Entry 0 is the oldest pixel, entry DEPTH-1 the newest
    rgb_pixel_t pix_buf [DEPTH];

    warm_cnt_t warm_cnt;
    logic      frame_started;
    logic      accept;
    logic      beat_warm;

    assign accept = valid && ready;

    // The sop beat is beat 0, so it is never warm
    assign beat_warm = accept && frame_started && !sop &&
                       (warm_cnt == warm_cnt_t'(WARM_BEATS));

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int k = 0; k < DEPTH - 1; k++) begin
                pix_buf[k] <= pix_buf[k+1];
            end
            pix_buf[DEPTH-1] <= pixel_in;
        end
    end

    // Warm-up counter holds the frame beat number, saturating at WARM_BEATS
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            warm_cnt      <= '0;
            frame_started <= 1'b0;
            win_valid     <= 1'b0;
        end else begin
            win_valid <= beat_warm;
            if (accept && sop) begin
                frame_started <= 1'b1;
                warm_cnt      <= warm_cnt_t'(1);
            end else if (accept && frame_started &&
                         warm_cnt != warm_cnt_t'(WARM_BEATS)) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
        end
    end

    // Tap (i, j) sits i rows and j pixels after the oldest pixel
    always_comb begin
        for (int i = 0; i < KERNEL_ROWS; i++) begin
            for (int j = 0; j < KERNEL_COLS; j++) begin
                window[0][i][j] = pix_buf[i * IMG_WIDTH + j].red;
                window[1][i][j] = pix_buf[i * IMG_WIDTH + j].green;
                window[2][i][j] = pix_buf[i * IMG_WIDTH + j].blue;
            end
        end
    end

    assign oldest = pix_buf[0];

    // A window is only flagged right after the buffer moved
    win_valid_after_accept: assert property (
        @(posedge clk) disable iff (!rst_n)
        win_valid |-> $past(valid && ready)
    );

endmodule

// File: logic/channel_blur.sv
`timescale 1ns/1ps

module channel_blur (
    input  logic                   clk,
    input  blur_pkg::chan_window_t taps,
    output blur_pkg::blur_acc_t    sum
);
    import blur_pkg::*;

    blur_acc_t acc_comb;

    // Weights are 0, 1, 2 or 4, so each product is a shift of the tap
    function automatic blur_acc_t weight_term(input channel_t tap, input int weight);
        blur_acc_t wide;
        wide = blur_acc_t'(tap);
        case (weight)
            1: begin
                weight_term = wide;
            end
            2: begin
                weight_term = wide << 1;
            end
            4: begin
                weight_term = wide << 2;
            end
            default: begin
                weight_term = '0;
            end
        endcase
    endfunction

    // Sum of all 35 weighted taps, fits in 10 bits
    always_comb begin
        acc_comb = '0;
        for (int i = 0; i < KERNEL_ROWS; i++) begin
            for (int j = 0; j < KERNEL_COLS; j++) begin
                acc_comb = acc_comb + weight_term(taps[i][j], KERNEL_WEIGHT[i][j]);
            end
        end
    end

    // Registered every cycle; qualification travels alongside in the merge stage
    always_ff @(posedge clk) begin
        sum <= acc_comb;
    end

endmodule

// File: logic/pixel_merge.sv
`timescale 1ns/1ps

module pixel_merge (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  blur_pkg::blur_acc_t [blur_pkg::NUM_CHANNELS-1:0] sums,
    input  blur_pkg::rgb_pixel_t                           oldest,
    input  logic                                           win_valid,
    output blur_pkg::rgb_pixel_t                           pixel_out,
    output logic                                           out_valid
);
    import blur_pkg::*;

    // Oldest pixel and valid, delayed to line up with the registered sums
    rgb_pixel_t oldest_d;
    logic       valid_d;

    channel_t [NUM_CHANNELS-1:0] blurred;
    channel_t [NUM_CHANNELS-1:0] old_chan;
    channel_t [NUM_CHANNELS-1:0] result;
    logic                        noise_hit;

    always_ff @(posedge clk) begin
        oldest_d <= oldest;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_d <= 1'b0;
        end else begin
            valid_d <= win_valid;
        end
    end

    assign old_chan[0] = oldest_d.red;
    assign old_chan[1] = oldest_d.green;
    assign old_chan[2] = oldest_d.blue;

    always_comb begin
        noise_hit = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            blurred[c] = channel_t'(sums[c] >> NORM_SHIFT);
            if (blurred[c] <= NOISE_LEVEL) begin
                noise_hit = 1'b0;
            end
        end
        // Bright areas get averaged with each channel's own oldest value
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (noise_hit) begin
                result[c] = channel_t'((5'(blurred[c]) + 5'(old_chan[c])) >> 1);
            end else begin
                result[c] = blurred[c];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel_out <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= valid_d;
            if (valid_d) begin
                pixel_out <= '{red: result[0], green: result[1], blue: result[2]};
            end
        end
    end

    // Two-stage latency from window to output
    out_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(win_valid, 2)
    );

endmodule

// File: logic/blur_filter_top.sv
`timescale 1ns/1ps

module blur_filter_top #(
    parameter int IMG_WIDTH = 320
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  blur_pkg::rgb_pixel_t pixel_in,
    input  logic                 valid,
    input  logic                 ready,
    input  logic                 sop,
    output blur_pkg::rgb_pixel_t pixel_out,
    output logic                 out_valid
);
    import blur_pkg::*;

    rgb_window_t                  window;
    rgb_pixel_t                   oldest;
    logic                         win_valid;
    blur_acc_t [NUM_CHANNELS-1:0] sums;

    // Shift buffer and warm-up tracking
    pixel_window #(
        .IMG_WIDTH (IMG_WIDTH)
    ) u_window (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_in  (pixel_in),
        .valid     (valid),
        .ready     (ready),
        .sop       (sop),
        .window    (window),
        .oldest    (oldest),
        .win_valid (win_valid)
    );

    // One weighted sum per colour channel
    for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_blur
        channel_blur u_blur (
            .clk  (clk),
            .taps (window[c]),
            .sum  (sums[c])
        );
    end

    // Normalise, apply the noise rule and pack
    pixel_merge u_merge (
        .clk       (clk),
        .rst_n     (rst_n),
        .sums      (sums),
        .oldest    (oldest),
        .win_valid (win_valid),
        .pixel_out (pixel_out),
        .out_valid (out_valid)
    );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Release on a falling edge so the DUT never sees rst_n change at its sampling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verif/blur_filter_tb.sv
`timescale 1ns/1ps

module blur_filter_tb;
    import blur_pkg::*;

    localparam int IMG_W       = 16;
    // Frame beat number of the first complete window
    localparam int WARM_BEATS  = (KERNEL_ROWS - 1) * IMG_W + KERNEL_COLS - 1;
    localparam int DRAIN_LIMIT = 64;
    localparam int RESET_LIMIT = 100;

    localparam int KIND_CONST  = 0;
    localparam int KIND_RAMP   = 1;
    localparam int KIND_RANDOM = 2;

    logic       clk;
    logic       rst_n;
    rgb_pixel_t pixel_in;
    logic       valid;
    logic       ready;
    logic       sop;
    rgb_pixel_t pixel_out;
    logic       out_valid;

    // Reference model state, the accepted beats of the current frame
    rgb_pixel_t frame_pix [$];
    logic       frame_active = 1'b0;
    logic       fixed_mode   = 1'b0;
    rgb_pixel_t fixed_value  = '0;

    // Expected results in beat order, with the cycle each one is due
    rgb_pixel_t exp_pix_q [$];
    int         exp_cyc_q [$];
    int         exp_beat_q [$];

    logic [31:0] lfsr_state = 32'h2d9e;
    int          cycle = 0;
    string       test_name = "";
    int          test_errors = 0;
    int          test_results = 0;
    int          error_count = 0;
    int          result_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    tb_clock_gen #(
        .PERIOD_NS    (8),
        .RESET_CYCLES (10)
    ) clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    blur_filter_top #(
        .IMG_WIDTH (IMG_W)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_in  (pixel_in),
        .valid     (valid),
        .ready     (ready),
        .sop       (sop),
        .pixel_out (pixel_out),
        .out_valid (out_valid)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            lfsr_next = (state >> 1) ^ 32'h8020_0003;
        end else begin
            lfsr_next = state >> 1;
        end
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int k = 0; k < count; k++) begin
            bits       = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    // Bright channels sit in 12..15 so the noise rule fires often there
    function automatic channel_t random_channel(input logic bright);
        logic [7:0] bits;
        if (bright) begin
            bits = random_bits(2);
            random_channel = {2'b11, bits[1:0]};
        end else begin
            bits = random_bits(4);
            random_channel = bits[3:0];
        end
    endfunction

    function automatic rgb_pixel_t random_pixel(input logic bright);
        rgb_pixel_t pix;
        pix.red   = random_channel(bright);
        pix.green = random_channel(bright);
        pix.blue  = random_channel(bright);
        return pix;
    endfunction

    function automatic int channel_value(input rgb_pixel_t pix, input int c);
        case (c)
            0: channel_value = int'(pix.red);
            1: channel_value = int'(pix.green);
            default: channel_value = int'(pix.blue);
        endcase
    endfunction

    // Expected output for warm frame beat n
    function automatic rgb_pixel_t expected_pixel(input int n);
        int         base;
        int         sum [NUM_CHANNELS];
        int         blur [NUM_CHANNELS];
        int         outv [NUM_CHANNELS];
        logic       noisy;
        rgb_pixel_t tap;
        rgb_pixel_t res;
        base  = n - WARM_BEATS;
        noisy = 1'b1;
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            sum[c] = 0;
        end
        for (int i = 0; i < KERNEL_ROWS; i++) begin
            for (int j = 0; j < KERNEL_COLS; j++) begin
                tap = frame_pix[base + i * IMG_W + j];
                for (int c = 0; c < NUM_CHANNELS; c++) begin
                    sum[c] = sum[c] + KERNEL_WEIGHT[i][j] * channel_value(tap, c);
                end
            end
        end
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            blur[c] = sum[c] >> NORM_SHIFT;
            if (blur[c] <= NOISE_LEVEL) begin
                noisy = 1'b0;
            end
        end
        // Average with the oldest pixel of the window, per channel
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (noisy) begin
                outv[c] = (blur[c] + channel_value(frame_pix[base], c)) >> 1;
            end else begin
                outv[c] = blur[c];
            end
        end
        res.red   = channel_t'(outv[0]);
        res.green = channel_t'(outv[1]);
        res.blue  = channel_t'(outv[2]);
        return res;
    endfunction

    function automatic void count_error();
        test_errors = test_errors + 1;
        error_count = error_count + 1;
    endfunction

    always @(negedge clk) begin : compare_results
        rgb_pixel_t want;
        int         due;
        int         beat;
        if (out_valid === 1'b1) begin
            if (exp_pix_q.size() == 0) begin
                $display("unexpected result at cycle %0d, pixel_out 0x%03h", cycle, pixel_out);
                count_error();
            end else begin
                want = exp_pix_q.pop_front();
                due  = exp_cyc_q.pop_front();
                beat = exp_beat_q.pop_front();
                test_results = test_results + 1;
                result_count = result_count + 1;
                if (pixel_out !== want) begin
                    $display("error: pixel_out = 0x%03h, expected 0x%03h (beat %0d)",
                             pixel_out, want, beat);
                    count_error();
                end
                if (cycle != due) begin
                    $display("result for beat %0d came at cycle %0d instead of cycle %0d",
                             beat, cycle, due);
                    count_error();
                end
            end
        end else if (exp_cyc_q.size() != 0 && exp_cyc_q[0] <= cycle) begin
            $display("no result for beat %0d at cycle %0d", exp_beat_q[0], cycle);
            count_error();
            void'(exp_pix_q.pop_front());
            void'(exp_cyc_q.pop_front());
            void'(exp_beat_q.pop_front());
        end
    end

    task automatic record_beat(input rgb_pixel_t pix, input logic start);
        int         n;
        rgb_pixel_t want;
        if (start) begin
            frame_pix.delete();
            frame_active = 1'b1;
        end
        if (frame_active) begin
            frame_pix.push_back(pix);
            n = frame_pix.size() - 1;
            if (n >= WARM_BEATS) begin
                if (fixed_mode) begin
                    want = fixed_value;
                end else begin
                    want = expected_pixel(n);
                end
                // Accepted on the next edge, visible after two more
                exp_pix_q.push_back(want);
                exp_cyc_q.push_back(cycle + 3);
                exp_beat_q.push_back(n);
            end
        end
    endtask

    task automatic drive_beat(input rgb_pixel_t pix, input logic v, input logic r,
                              input logic start);
        @(negedge clk);
        pixel_in = pix;
        valid    = v;
        ready    = r;
        sop      = start;
        if (v && r) begin
            record_beat(pix, start);
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        valid = 1'b0;
        ready = 1'b0;
        sop   = 1'b0;
    endtask

    // Sends count accepted beats, optionally with random stall cycles in between
    task automatic send_beats(input int count, input logic start_frame, input int kind,
                              input logic gaps);
        rgb_pixel_t pix;
        logic       bright;
        logic       first;
        logic [7:0] bits;
        int         stalls;
        for (int k = 0; k < count; k++) begin
            first  = start_frame && (k == 0);
            bright = ((k / 24) % 2) == 1;
            case (kind)
                KIND_CONST: pix = fixed_value;
                KIND_RAMP: pix = rgb_pixel_t'(12'(k * 37));
                default: pix = random_pixel(bright);
            endcase
            stalls = 0;
            while (gaps && stalls < 8 && random_bits(2) == 8'd0) begin
                bits = random_bits(1);
                drive_beat(pix, bits[0], !bits[0], first);
                stalls++;
            end
            drive_beat(pix, 1'b1, 1'b1, first);
        end
    endtask

    task automatic start_test(input string name);
        test_name    = name;
        test_errors  = 0;
        test_results = 0;
    endtask

    task automatic finish_test(input int want_results);
        int waited;
        waited = 0;
        drive_idle();
        while (exp_pix_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (exp_pix_q.size() != 0) begin
            $display("timed out with %0d results still pending in %s", exp_pix_q.size(),
                     test_name);
            count_error();
            exp_pix_q.delete();
            exp_cyc_q.delete();
            exp_beat_q.delete();
        end
        // A few quiet cycles catch any stray result
        repeat (4) drive_idle();
        if (test_results != want_results) begin
            $display("%s produced %0d results instead of %0d", test_name, test_results,
                     want_results);
            count_error();
        end
        tests_run = tests_run + 1;
        if (test_errors != 0) begin
            tests_failed = tests_failed + 1;
        end
        $display("test %s: %0d results, %0d errors", test_name, test_results, test_errors);
    endtask

    initial begin : run_tests
        int waited;
        pixel_in = '0;
        valid    = 1'b0;
        ready    = 1'b0;
        sop      = 1'b0;
        waited   = 0;
        while (rst_n !== 1'b1 && waited < RESET_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            count_error();
        end

        start_test("no_sop");
        if (out_valid !== 1'b0) begin
            $display("error: out_valid = 0x%h after reset, expected 0x0", out_valid);
            count_error();
        end
        if (pixel_out !== 12'h000) begin
            $display("error: pixel_out = 0x%03h after reset, expected 0x000", pixel_out);
            count_error();
        end
        send_beats(100, 1'b0, KIND_RANDOM, 1'b0);
        finish_test(0);

        start_test("warm_up");
        send_beats(8 * IMG_W, 1'b1, KIND_RAMP, 1'b0);
        finish_test(8 * IMG_W - WARM_BEATS);

        start_test("const_5");
        fixed_mode  = 1'b1;
        fixed_value = 12'h555;
        send_beats(100, 1'b1, KIND_CONST, 1'b0);
        finish_test(100 - WARM_BEATS);

        start_test("const_15");
        fixed_value = 12'hfff;
        send_beats(100, 1'b1, KIND_CONST, 1'b0);
        finish_test(100 - WARM_BEATS);
        fixed_mode = 1'b0;

        start_test("random");
        send_beats(10 * IMG_W, 1'b1, KIND_RANDOM, 1'b0);
        finish_test(10 * IMG_W - WARM_BEATS);

        start_test("random_gaps");
        send_beats(10 * IMG_W, 1'b1, KIND_RANDOM, 1'b1);
        finish_test(10 * IMG_W - WARM_BEATS);

        // Second sop arrives while the first frame is still streaming
        start_test("restart");
        send_beats(100, 1'b1, KIND_RANDOM, 1'b0);
        send_beats(120, 1'b1, KIND_RANDOM, 1'b1);
        finish_test((100 - WARM_BEATS) + (120 - WARM_BEATS));

        $display("summary: %0d tests, %0d failed, %0d results checked, %0d errors",
                 tests_run, tests_failed, result_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
logic/blur_pkg.sv
logic/pixel_window.sv
logic/channel_blur.sv
logic/pixel_merge.sv
logic/blur_filter_top.sv
verif/tb_clock_gen.sv
verif/blur_filter_tb.sv

// File: Makefile
# Verilator build and run of the blur filter testbench

SIM  := obj_dir/Vblur_filter_tb
SRCS := $(shell cat tb.f)

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module blur_filter_tb -f tb.f

# The log decides pass or fail
run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
